// File: verilog/gsim_pkg.sv
`default_nettype none

package gsim_pkg;

    // problem size
    localparam int N_UNK  = 16;     // unknowns per system
    localparam int IDX_W  = 4;      // bits to address one unknown

    // number formats
    localparam int B_W    = 16;     // signed integer right-hand side
    localparam int X_W    = 32;     // signed Q16.16 solution value
    localparam int FRAC_W = 16;     // fractional bits in x
    localparam int ACC_W  = 37;     // weighted sum, five guard bits over x

    // band magnitudes, signs are -, +, - going outward from the diagonal
    localparam int COEF_D1 = 13;    // distance 1
    localparam int COEF_D2 = 6;     // distance 2
    localparam int COEF_D3 = 1;     // distance 3

    // iteration control
    localparam int NUM_SWEEPS = 100; // full passes over all unknowns per job
    localparam int SWEEP_W    = 7;   // holds 0..NUM_SWEEPS-1

    typedef logic signed [B_W-1:0]   b_t;    // b value
    typedef logic signed [X_W-1:0]   x_t;    // x value, Q16.16
    typedef logic        [IDX_W-1:0] idx_t;  // unknown index
    typedef logic signed [ACC_W-1:0] acc_t;  // update accumulator

    // job sequencing
    typedef enum logic [1:0] {
        ST_LOAD   = 2'd0,   // taking b values
        ST_SOLVE  = 2'd1,   // issuing one update per cycle
        ST_DRAIN  = 2'd2,   // last update still in the stage register
        ST_OUTPUT = 2'd3    // presenting x values
    } seq_state_t;

endpackage : gsim_pkg

`default_nettype wire

// File: verilog/gsim_div20.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_div20 (
    input  wire gsim_pkg::acc_t sum,
    output gsim_pkg::x_t        quotient
);
    import gsim_pkg::*;

    // 1/20 ~ (1 + 1/2)(1 + 2^-4 + 2^-8 + ... + 2^-28) / 32
    acc_t pair  [8];   // sum>>>4k + sum>>>(4k+1)
    acc_t quad  [4];   // adjacent pairs added
    acc_t octet [2];   // adjacent quads added
    acc_t total;       // 32 * sum / 20, before the final shift

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            pair[k] = (sum >>> (4 * k)) + (sum >>> (4 * k + 1));   // arithmetic shifts
        end
    end

    // balanced tree keeps the adder depth at four
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            quad[k] = pair[2 * k] + pair[2 * k + 1];
        end
        for (int k = 0; k < 2; k++) begin
            octet[k] = quad[2 * k] + quad[2 * k + 1];
        end
        total = octet[0] + octet[1];
    end

    // drop five bits, round half up using the highest dropped bit
    assign quotient = total[ACC_W-1:ACC_W-X_W] + X_W'(total[ACC_W-X_W-1]);

endmodule : gsim_div20

`default_nettype wire

// File: verilog/gsim_weighted_sum.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_weighted_sum (
    input  wire logic           clk_in,
    input  wire logic           rst_in,
    input  wire logic           issue_en,
    input  wire gsim_pkg::idx_t issue_idx,
    input  wire gsim_pkg::b_t   b_sel,
    input  wire gsim_pkg::x_t   xm1,
    input  wire gsim_pkg::x_t   xp1,
    input  wire gsim_pkg::x_t   xm2,
    input  wire gsim_pkg::x_t   xp2,
    input  wire gsim_pkg::x_t   xm3,
    input  wire gsim_pkg::x_t   xp3,
    output gsim_pkg::acc_t      sum,
    output logic                sum_valid,
    output gsim_pkg::idx_t      sum_idx
);
    import gsim_pkg::*;

    acc_t b_term;    // b scaled up to Q16.16
    acc_t pair1;     // xm1 + xp1
    acc_t pair2;     // xm2 + xp2
    acc_t pair3;     // xm3 + xp3
    acc_t sum_nxt;   // full banded sum

    always_comb begin
        b_term  = acc_t'(b_sel) <<< FRAC_W;     // b * 2^16, sign kept
        pair1   = acc_t'(xm1) + acc_t'(xp1);    // symmetric pairs first
        pair2   = acc_t'(xm2) + acc_t'(xp2);
        pair3   = acc_t'(xm3) + acc_t'(xp3);
        sum_nxt = b_term + pair1 * COEF_D1      // moving -13 to the right side
                - pair2 * COEF_D2               // +6 becomes a subtract
                + pair3 * COEF_D3;              // -1 becomes an add
    end

    // pipeline stage, payload carries no reset
    always_ff @(posedge clk_in) begin
        sum     <= sum_nxt;
        sum_idx <= issue_idx;
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= issue_en;   // becomes the write enable next cycle
        end
    end

endmodule : gsim_weighted_sum

`default_nettype wire

// File: verilog/gsim_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_regfile (
    input  wire logic           clk_in,
    input  wire logic           rst_in,
    input  wire logic           load_en,
    input  wire gsim_pkg::idx_t load_idx,
    input  wire gsim_pkg::b_t   b_in,
    input  wire gsim_pkg::idx_t issue_idx,
    output gsim_pkg::b_t        b_sel,
    output gsim_pkg::x_t        xm1,
    output gsim_pkg::x_t        xp1,
    output gsim_pkg::x_t        xm2,
    output gsim_pkg::x_t        xp2,
    output gsim_pkg::x_t        xm3,
    output gsim_pkg::x_t        xp3,
    input  wire logic           wr_en,
    input  wire gsim_pkg::idx_t wr_idx,
    input  wire gsim_pkg::x_t   wr_x,
    input  wire gsim_pkg::idx_t rd_idx,
    output gsim_pkg::x_t        x_out
);
    import gsim_pkg::*;

    b_t b_mem [N_UNK];   // right-hand side, one per unknown
    x_t x_mem [N_UNK];   // current solution estimate

    // neighbour at base+offset, zero off either end of the band
    function automatic x_t gather(input idx_t base, input int offset);
        int n;
        n = int'(base) + offset;
        if (n < 0 || n >= N_UNK) begin
            return '0;   // outside 0..15 contributes nothing
        end
        return x_mem[n[IDX_W-1:0]];
    endfunction

    // b only changes during load
    always_ff @(posedge clk_in) begin
        if (load_en) begin
            b_mem[load_idx] <= b_in;
        end
    end

    // x bank, load clears the slot so every job starts from zero
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            for (int i = 0; i < N_UNK; i++) begin
                x_mem[i] <= '0;
            end
        end else if (load_en) begin
            x_mem[load_idx] <= '0;
        end else if (wr_en) begin
            x_mem[wr_idx] <= wr_x;   // result of the stage update
        end
    end

    // operands for the issued index, same cycle
    always_comb begin
        b_sel = b_mem[issue_idx];
        xm1   = gather(issue_idx, -1);
        xp1   = gather(issue_idx, 1);
        xm2   = gather(issue_idx, -2);
        xp2   = gather(issue_idx, 2);
        xm3   = gather(issue_idx, -3);
        xp3   = gather(issue_idx, 3);
    end

    assign x_out = x_mem[rd_idx];   // readout port for the output stream

endmodule : gsim_regfile

`default_nettype wire

// File: verilog/gsim_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_sequencer (
    input  wire logic           clk_in,
    input  wire logic           rst_in,
    input  wire logic           in_valid,
    output logic                in_ready,
    output logic                out_valid,
    input  wire logic           out_ready,
    output logic                load_en,
    output gsim_pkg::idx_t      load_idx,
    output logic                issue_en,
    output gsim_pkg::idx_t      issue_idx,
    output gsim_pkg::idx_t      rd_idx
);
    import gsim_pkg::*;

    seq_state_t         state;     // job phase
    idx_t               pos;       // load, sweep or output position
    logic [SWEEP_W-1:0] sweep;     // completed sweeps in this job
    logic               in_hs;     // input transfer this cycle
    logic               out_hs;    // output transfer this cycle
    logic               last_pos;  // position 15 reached
    logic               last_sweep; // final sweep of the job

    // handshakes straight from state, so both streams hold while stalled
    always_comb begin
        in_ready  = (state == ST_LOAD);    // only take b while loading
        out_valid = (state == ST_OUTPUT);  // x bank is final here
        in_hs     = in_valid && in_ready;
        out_hs    = out_valid && out_ready;
    end

    always_comb begin
        last_pos   = (pos == idx_t'(N_UNK - 1));
        last_sweep = (sweep == SWEEP_W'(NUM_SWEEPS - 1));
    end

    // strobes and indices toward the datapath
    always_comb begin
        load_en   = in_hs;                    // b arrives in index order
        load_idx  = pos;
        issue_en  = (state == ST_SOLVE);      // one update every solve cycle
        issue_idx = {pos[1:0], pos[3:2]};     // 0,4,8,12,1,5,... ordering
        rd_idx    = pos;                      // readout in index order
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state <= ST_LOAD;
            pos   <= '0;
            sweep <= '0;
        end else begin
            unique case (state)
                ST_LOAD: begin
                    if (in_hs) begin
                        pos <= pos + 1'b1;        // wraps to 0 after b15
                        if (last_pos) begin
                            state <= ST_SOLVE;
                            sweep <= '0;          // fresh sweep count per job
                        end
                    end
                end
                ST_SOLVE: begin
                    pos <= pos + 1'b1;            // position wraps each sweep
                    if (last_pos) begin
                        sweep <= sweep + 1'b1;
                        if (last_sweep) begin
                            state <= ST_DRAIN;    // final issue done
                        end
                    end
                end
                ST_DRAIN: begin
                    // last update lands at the end of this cycle
                    state <= ST_OUTPUT;
                end
                ST_OUTPUT: begin
                    if (out_hs) begin
                        pos <= pos + 1'b1;
                        if (last_pos) begin
                            state <= ST_LOAD;     // ready for the next job
                        end
                    end
                end
            endcase
        end
    end

endmodule : gsim_sequencer

`default_nettype wire

// File: verilog/gsim_top.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_top (
    input  wire logic         clk_in,
    input  wire logic         rst_in,
    input  wire logic         in_valid,
    output logic              in_ready,
    input  wire gsim_pkg::b_t b_in,
    output logic              out_valid,
    input  wire logic         out_ready,
    output gsim_pkg::x_t      x_out
);
    import gsim_pkg::*;

    logic load_en;     // b write strobe from sequencer
    idx_t load_idx;    // index being loaded
    logic issue_en;    // update issue strobe
    idx_t issue_idx;   // index being updated
    idx_t rd_idx;      // readout index
    b_t   b_sel;       // b of the issued index
    x_t   xm1, xp1;    // distance-1 neighbours
    x_t   xm2, xp2;    // distance-2 neighbours
    x_t   xm3, xp3;    // distance-3 neighbours
    acc_t sum;         // registered weighted sum
    logic sum_valid;   // stage holds a live update
    idx_t sum_idx;     // index the stage belongs to
    x_t   x_new;       // divided result, written back

    gsim_sequencer u_seq (
        .clk_in, .rst_in,
        .in_valid, .in_ready,
        .out_valid, .out_ready,
        .load_en, .load_idx,
        .issue_en, .issue_idx,
        .rd_idx
    );

    gsim_regfile u_rf (
        .clk_in, .rst_in,
        .load_en, .load_idx, .b_in,
        .issue_idx, .b_sel,
        .xm1, .xp1, .xm2, .xp2, .xm3, .xp3,
        .wr_en  (sum_valid),   // write back one cycle after issue
        .wr_idx (sum_idx),
        .wr_x   (x_new),
        .rd_idx, .x_out
    );

    gsim_weighted_sum u_wsum (
        .clk_in, .rst_in,
        .issue_en, .issue_idx, .b_sel,
        .xm1, .xp1, .xm2, .xp2, .xm3, .xp3,
        .sum, .sum_valid, .sum_idx
    );

    gsim_div20 u_div (
        .sum,
        .quotient (x_new)
    );

endmodule : gsim_top

`default_nettype wire

// File: dv/gsim_chk.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_chk (
    input wire logic         clk_in,
    input wire logic         rst_in,
    input wire logic         in_ready,
    input wire logic         out_valid,
    input wire logic         out_ready,
    input wire gsim_pkg::x_t x_out
);

    // loading and readout are separate phases
    a_phase_excl: assert property (@(posedge clk_in) disable iff (rst_in)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    // stalled output keeps its value
    a_out_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        (out_valid && !out_ready) |=> (out_valid && $stable(x_out)))
        else $error("output changed while stalled");

    a_reset_idle: assert property (@(posedge clk_in)
        $fell(rst_in) |-> !out_valid)
        else $error("out_valid high right after reset");

endmodule : gsim_chk

bind gsim_top gsim_chk u_chk (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .x_out     (x_out)
);

`default_nettype wire

// File: dv/gsim_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gsim_tb;
    import gsim_pkg::*;

    localparam int N_TESTS     = 6;
    localparam int LOAD_WAIT   = 200;                    // cycles allowed per input value
    localparam int OUT_WAIT    = NUM_SWEEPS * N_UNK + 800; // solve time plus stall slack
    localparam int FIRST_OUT   = NUM_SWEEPS * N_UNK + 2; // last input to first out_valid
    localparam bit FILL_EXPLICIT = 1'b0;
    localparam bit FILL_LCG      = 1'b1;

    logic clk_in = 1'b0;
    logic rst_in;
    logic in_valid;
    logic in_ready;
    b_t   b_in;
    logic out_valid;
    logic out_ready;
    x_t   x_out;

    // test table, one row per job
    string name_tbl  [N_TESTS];
    b_t    b_tbl     [N_TESTS][N_UNK];
    bit    fill_tbl  [N_TESTS];     // explicit values or lcg fill
    bit    stall_tbl [N_TESTS];     // lcg-driven out_ready when set
    bit    chain_tbl [N_TESTS];     // keep in_valid high into the next job
    x_t    exp_x     [N_TESTS][N_UNK];

    longint      model_x [N_UNK];   // reference solution while solving
    logic [31:0] lcg_state;
    int          cycle;
    int          last_in_cycle;     // cycle of the latest input transfer
    int          errors;
    int          passes;
    int          err_before;
    bit          timed_out;

    gsim_top DUT (
        .clk_in, .rst_in,
        .in_valid, .in_ready, .b_in,
        .out_valid, .out_ready, .x_out
    );

    always #5 clk_in = ~clk_in;              // 10 ns period

    always @(posedge clk_in) cycle <= cycle + 1;  // stable when sampled at negedge

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // sign-extend the low w bits of v
    function automatic longint sign_wrap(input longint v, input int w);
        return (v <<< (64 - w)) >>> (64 - w);
    endfunction

    function automatic longint model_at(input int n);
        if (n < 0 || n >= N_UNK) begin
            return 0;                        // outside the band
        end
        return model_x[n];
    endfunction

    // gauss-seidel in the interleaved order, each write seen at once
    function automatic void solve_model(input int t);
        int     i;
        longint s;
        longint tot;
        longint q;
        for (int k = 0; k < N_UNK; k++) model_x[k] = 0;
        for (int sw = 0; sw < NUM_SWEEPS; sw++) begin
            for (int p = 0; p < N_UNK; p++) begin
                i = 4 * (p % 4) + p / 4;
                s = longint'(b_tbl[t][i]) * 65536
                  + COEF_D1 * (model_at(i - 1) + model_at(i + 1))
                  - COEF_D2 * (model_at(i - 2) + model_at(i + 2))
                  + COEF_D3 * (model_at(i - 3) + model_at(i + 3));
                s   = sign_wrap(s, ACC_W);
                tot = 0;
                for (int k = 0; k < 16; k++) begin
                    tot = tot + (s >>> ((k / 2) * 4 + k % 2));  // shifts 0,1,4,5,...,28,29
                end
                tot = sign_wrap(tot, ACC_W);
                q   = (tot >>> 5) + ((tot >>> 4) & 64'sd1);    // round on bit 4
                model_x[i] = sign_wrap(q, X_W);
            end
        end
        for (int k = 0; k < N_UNK; k++) exp_x[t][k] = x_t'(model_x[k]);
    endfunction

    task automatic build_table();
        name_tbl[0] = "zero b";
        name_tbl[1] = "small b";
        name_tbl[2] = "full range";
        name_tbl[3] = "out stall";
        name_tbl[4] = "chain first";
        name_tbl[5] = "chain second";
        fill_tbl  = '{FILL_EXPLICIT, FILL_EXPLICIT, FILL_LCG, FILL_LCG, FILL_LCG, FILL_EXPLICIT};
        stall_tbl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
        chain_tbl = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        b_tbl[0] = '{default: '0};
        b_tbl[1] = '{16'sd1, 16'sd2, -16'sd3, 16'sd4, 16'sd0, -16'sd7, 16'sd5, 16'sd9,
                     -16'sd2, 16'sd6, 16'sd3, -16'sd1, 16'sd8, 16'sd0, -16'sd4, 16'sd2};
        b_tbl[5] = '{16'sd10, -16'sd10, 16'sd3, 16'sd0, 16'sd0, 16'sd1, -16'sd6, 16'sd2,
                     16'sd7, -16'sd5, 16'sd0, 16'sd4, -16'sd9, 16'sd1, 16'sd12, -16'sd3};
        for (int r = 0; r < N_TESTS; r++) begin
            if (fill_tbl[r] == FILL_LCG) begin
                for (int k = 0; k < N_UNK; k++) b_tbl[r][k] = b_t'(lcg_next() >> 16);
            end
        end
        b_tbl[2][0]  = 16'sh8000;            // both ends of the signed range
        b_tbl[2][15] = 16'sh7fff;
    endtask

    // offer the 16 b values of row t in index order
    task automatic load_job(input int t);
        int waited;
        for (int k = 0; k < N_UNK; k++) begin
            in_valid <= 1'b1;
            b_in     <= b_tbl[t][k];
            waited = 0;
            do begin
                @(negedge clk_in);
                waited++;
                assert (!out_valid) else begin
                    $display("FAILED out_valid: expected 0, got %0h while loading test %0d",
                             out_valid, t);
                    errors++;
                end
            end while (!in_ready && waited < LOAD_WAIT);
            if (!in_ready) begin
                $display("test %0d: input value %0d was never accepted", t, k);
                timed_out = 1'b1;
                errors++;
                return;
            end
            last_in_cycle = cycle;            // transfer at the coming edge
            @(posedge clk_in);
        end
        if (chain_tbl[t] && t + 1 < N_TESTS) begin
            b_in <= b_tbl[t + 1][0];          // in_valid stays high, must wait
        end else begin
            in_valid <= 1'b0;
        end
    endtask

    // take the 16 results, ends right after the last transfer edge
    task automatic collect_job(input int t);
        int          waited;
        int          count;
        bit          seen;
        logic [31:0] draw;
        count  = 0;
        waited = 0;
        seen   = 1'b0;
        while (count < N_UNK && waited < OUT_WAIT) begin
            if (stall_tbl[t]) begin
                draw = lcg_next();
                out_ready <= (draw[21:20] != 2'b00);   // ready about 3 of 4 cycles
            end else begin
                out_ready <= 1'b1;
            end
            @(negedge clk_in);
            waited++;
            assert (!in_ready) else begin
                $display("FAILED in_ready: expected 0, got %0h with results of test %0d pending",
                         in_ready, t);
                errors++;
            end
            if (out_valid && !seen) begin
                seen = 1'b1;
                assert (cycle - last_in_cycle == FIRST_OUT) else begin
                    $display("FAILED out_valid delay: expected %0h, got %0h cycles",
                             FIRST_OUT, cycle - last_in_cycle);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                assert (x_out == exp_x[t][count]) else begin
                    $display("FAILED x_out[%0d]: expected %08h, got %08h",
                             count, exp_x[t][count], x_out);
                    errors++;
                end
                count++;
            end
            @(posedge clk_in);
        end
        out_ready <= 1'b0;
        if (count < N_UNK) begin
            $display("test %0d: only %0d of %0d results arrived in time", t, count, N_UNK);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    initial begin
        rst_in    = 1'b1;
        in_valid  = 1'b0;
        b_in      = '0;
        out_ready = 1'b0;
        cycle     = 0;
        errors    = 0;
        passes    = 0;
        timed_out = 1'b0;
        lcg_state = 32'd1149;
        build_table();
        for (int t = 0; t < N_TESTS; t++) solve_model(t);   // expected values up front

        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        assert (in_ready && !out_valid) else begin
            $display("FAILED after reset: in_ready %0h out_valid %0h, expected 1 and 0",
                     in_ready, out_valid);
            errors++;
        end
        @(posedge clk_in);

        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            err_before = errors;
            load_job(t);
            if (!timed_out) collect_job(t);
            if (errors == err_before) begin
                passes++;
                $display("test %0d %s: ok", t, name_tbl[t]);
            end else begin
                $display("test %0d %s: %0d errors", t, name_tbl[t], errors - err_before);
            end
        end

        $display("%0d of %0d tests passed, %0d errors", passes, N_TESTS, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : gsim_tb

`default_nettype wire

// File: vlog.f
verilog/gsim_pkg.sv
verilog/gsim_div20.sv
verilog/gsim_weighted_sum.sv
verilog/gsim_regfile.sv
verilog/gsim_sequencer.sv
verilog/gsim_top.sv
dv/gsim_chk.sv
dv/gsim_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := gsim_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
